/* core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Width of one data word
`define DATA_WIDTH 32

// Width of an instruction word
`define INSTR_WIDTH 32

// Register address and count
`define REG_ADDR_W 5
`define REG_COUNT 32

// Shift amount field and the low bits of rs used by variable shifts
`define SHAMT_W 5

`endif

/* isa_pkg.sv */
package isa_pkg;

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////

    // Major opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // Function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    //////////////////////////////
    // Internal operations
    //////////////////////////////

    // ALU operation
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    // Shifter operation
    typedef enum logic [1:0] {
        SH_SLL,
        SH_SRL,
        SH_SRA
    } shift_op_e;

    // Result source in execute
    typedef enum logic {
        EXRES_ALU,
        EXRES_SHIFT
    } exres_sel_e;

endpackage

/* pipe_pkg.sv */
`include "core_macros.svh"

package pipe_pkg;

    //////////////////////////////
    // Stage records
    //////////////////////////////

    // Decoded operation, decode to execute
    typedef struct packed {
        logic                      valid;
        // Instruction writes a register
        logic                      reg_w;
        logic [`REG_ADDR_W-1:0]    rs_addr;
        logic [`REG_ADDR_W-1:0]    rt_addr;
        logic [`REG_ADDR_W-1:0]    rd_addr;
        // Register file data read in decode
        logic [`DATA_WIDTH-1:0]    op_a;
        logic [`DATA_WIDTH-1:0]    op_b;
        logic [`DATA_WIDTH-1:0]    imm_ext;
        // Operand B from the immediate
        logic                      b_sel;
        isa_pkg::alu_op_e          alu_op;
        isa_pkg::shift_op_e        shift_op;
        logic [`SHAMT_W-1:0]       shamt;
        // Shift amount from rs instead of the shamt field
        logic                      shamt_sel;
        isa_pkg::exres_sel_e       exres_sel;
    } idex_t;

    // Write-back record, execute to register file and outputs
    typedef struct packed {
        logic                      valid;
        logic [`REG_ADDR_W-1:0]    rd_addr;
        logic [`DATA_WIDTH-1:0]    data;
    } wb_t;

endpackage

/* instr_decoder.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module instr_decoder (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [`INSTR_WIDTH-1:0]   instr,
    output logic [`REG_ADDR_W-1:0]    rs_addr,
    output logic [`REG_ADDR_W-1:0]    rt_addr,
    input  logic [`DATA_WIDTH-1:0]    rs_data,
    input  logic [`DATA_WIDTH-1:0]    rt_data,
    output pipe_pkg::idex_t           idex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // Raw instruction fields
    logic [5:0]               op_field;
    logic [5:0]               fn_field;
    logic [`REG_ADDR_W-1:0]   rd_field;
    logic [`SHAMT_W-1:0]      shamt_field;
    logic [15:0]              imm_field;

    // Decode flags
    logic                     legal;
    logic                     r_type;
    logic                     sign_ext;
    idex_t                    idex_next;

    //////////////////////////////
    // Field split
    //////////////////////////////

    assign op_field    = instr[31:26];
    assign rs_addr     = instr[25:21];
    assign rt_addr     = instr[20:16];
    assign rd_field    = instr[15:11];
    assign shamt_field = instr[10:6];
    assign fn_field    = instr[5:0];
    assign imm_field   = instr[15:0];

    //////////////////////////////
    // Opcode and function decode
    //////////////////////////////

    always_comb begin
        legal     = 1'b1;
        r_type    = 1'b0;
        sign_ext  = 1'b0;
        idex_next = '0;
        // Defaults give an ALU add
        idex_next.alu_op    = ALU_ADD;
        idex_next.shift_op  = SH_SLL;
        idex_next.exres_sel = EXRES_ALU;
        case (opcode_e'(op_field))
            OP_SPECIAL: begin
                r_type = 1'b1;
                case (funct_e'(fn_field))
                    FN_ADDU: idex_next.alu_op = ALU_ADD;
                    FN_SUBU: idex_next.alu_op = ALU_SUB;
                    FN_AND:  idex_next.alu_op = ALU_AND;
                    FN_OR:   idex_next.alu_op = ALU_OR;
                    FN_XOR:  idex_next.alu_op = ALU_XOR;
                    FN_NOR:  idex_next.alu_op = ALU_NOR;
                    FN_SLT:  idex_next.alu_op = ALU_SLT;
                    FN_SLTU: idex_next.alu_op = ALU_SLTU;
                    // Shifts take the shifter result
                    FN_SLL, FN_SLLV: begin
                        idex_next.exres_sel = EXRES_SHIFT;
                        idex_next.shift_op  = SH_SLL;
                    end
                    FN_SRL, FN_SRLV: begin
                        idex_next.exres_sel = EXRES_SHIFT;
                        idex_next.shift_op  = SH_SRL;
                    end
                    FN_SRA, FN_SRAV: begin
                        idex_next.exres_sel = EXRES_SHIFT;
                        idex_next.shift_op  = SH_SRA;
                    end
                    default: legal = 1'b0;
                endcase
            end
            // Arithmetic and compares sign-extend
            OP_ADDIU: begin
                sign_ext         = 1'b1;
                idex_next.alu_op = ALU_ADD;
            end
            OP_SLTI: begin
                sign_ext         = 1'b1;
                idex_next.alu_op = ALU_SLT;
            end
            OP_SLTIU: begin
                sign_ext         = 1'b1;
                idex_next.alu_op = ALU_SLTU;
            end
            // Logic ops zero-extend
            OP_ANDI: idex_next.alu_op = ALU_AND;
            OP_ORI:  idex_next.alu_op = ALU_OR;
            OP_XORI: idex_next.alu_op = ALU_XOR;
            OP_LUI:  idex_next.alu_op = ALU_LUI;
            default: legal = 1'b0;
        endcase

        // Bubble unless strobed and known
        idex_next.valid     = instr_valid & legal;
        idex_next.reg_w     = legal;
        idex_next.rs_addr   = rs_addr;
        idex_next.rt_addr   = rt_addr;
        // rd for R-type, rt for I-type
        idex_next.rd_addr   = r_type ? rd_field : rt_addr;
        idex_next.op_a      = rs_data;
        idex_next.op_b      = rt_data;
        idex_next.b_sel     = ~r_type;
        idex_next.imm_ext   = sign_ext ? {{16{imm_field[15]}}, imm_field} : {16'h0000, imm_field};
        idex_next.shamt     = shamt_field;
        // Variable shifts use rs as the amount
        idex_next.shamt_sel = r_type && (funct_e'(fn_field) inside {FN_SLLV, FN_SRLV, FN_SRAV});
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (reset) begin
            idex <= '0;
        end else begin
            idex <= idex_next;
        end
    end

endmodule

/* gpr.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module gpr (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`REG_ADDR_W-1:0]    rs_addr,
    input  logic [`REG_ADDR_W-1:0]    rt_addr,
    output logic [`DATA_WIDTH-1:0]    rs_data,
    output logic [`DATA_WIDTH-1:0]    rt_data,
    input  pipe_pkg::wb_t             wb
);
    import pipe_pkg::*;

    // Architectural registers
    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // One read port, zero register first, then write-through
    function automatic logic [`DATA_WIDTH-1:0] read_port(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`DATA_WIDTH-1:0] stored,
        input wb_t                    rec
    );
        if (addr == '0) begin
            return '0;
        end
        if (rec.valid && rec.rd_addr == addr) begin
            return rec.data;
        end
        return stored;
    endfunction

    assign rs_data = read_port(rs_addr, regs[rs_addr], wb);
    assign rt_data = read_port(rt_addr, regs[rt_addr], wb);

    // Write port, register 0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd_addr != '0) begin
            regs[wb.rd_addr] <= wb.data;
        end
    end

endmodule

/* exec_stage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_stage (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::idex_t    idex,
    output pipe_pkg::wb_t      wb
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // Operands after forwarding
    logic [`DATA_WIDTH-1:0] op_a;
    logic [`DATA_WIDTH-1:0] op_b;
    // ALU operand B after immediate select
    logic [`DATA_WIDTH-1:0] alu_b;
    logic [`SHAMT_W-1:0]    shamt;

    // Result candidates
    logic [`DATA_WIDTH-1:0] alu_out;
    logic [`DATA_WIDTH-1:0] shift_out;
    wb_t                    wb_next;

    //////////////////////////////
    // Forwarding
    //////////////////////////////

    // Previous instruction still in wb, newer than the decode-time read
    assign op_a = (wb.valid && wb.rd_addr == idex.rs_addr) ? wb.data : idex.op_a;
    assign op_b = (wb.valid && wb.rd_addr == idex.rt_addr) ? wb.data : idex.op_b;

    // Immediate or register for B
    assign alu_b = idex.b_sel ? idex.imm_ext : op_b;

    // Fixed shamt or low bits of rs
    assign shamt = idex.shamt_sel ? op_a[`SHAMT_W-1:0] : idex.shamt;

    //////////////////////////////
    // ALU
    //////////////////////////////

    always_comb begin
        case (idex.alu_op)
            ALU_ADD:  alu_out = op_a + alu_b;
            ALU_SUB:  alu_out = op_a - alu_b;
            ALU_AND:  alu_out = op_a & alu_b;
            ALU_OR:   alu_out = op_a | alu_b;
            ALU_XOR:  alu_out = op_a ^ alu_b;
            ALU_NOR:  alu_out = ~(op_a | alu_b);
            // Signed compare
            ALU_SLT:  alu_out = {{(`DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            // Unsigned compare
            ALU_SLTU: alu_out = {{(`DATA_WIDTH-1){1'b0}}, op_a < alu_b};
            // Immediate into the upper half
            ALU_LUI:  alu_out = {alu_b[`DATA_WIDTH/2-1:0], {(`DATA_WIDTH/2){1'b0}}};
            default:  alu_out = '0;
        endcase
    end

    //////////////////////////////
    // Barrel shifter
    //////////////////////////////

    // Shifts rt, never the immediate
    always_comb begin
        case (idex.shift_op)
            SH_SLL:  shift_out = op_b << shamt;
            SH_SRL:  shift_out = op_b >> shamt;
            // Arithmetic right keeps the sign
            SH_SRA:  shift_out = $signed(op_b) >>> shamt;
            default: shift_out = op_b;
        endcase
    end

    //////////////////////////////
    // Write-back record
    //////////////////////////////

    always_comb begin
        wb_next.valid   = idex.valid && idex.reg_w && (idex.rd_addr != '0);
        wb_next.rd_addr = idex.rd_addr;
        wb_next.data    = (idex.exres_sel == EXRES_SHIFT) ? shift_out : alu_out;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb <= wb_next;
        end
    end

endmodule

/* pipeline.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module pipeline (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [`INSTR_WIDTH-1:0]   instr,
    output logic                      wb_valid,
    output logic [`REG_ADDR_W-1:0]    wb_addr,
    output logic [`DATA_WIDTH-1:0]    wb_data
);
    import pipe_pkg::*;

    // Register file read path
    logic [`REG_ADDR_W-1:0] rs_addr;
    logic [`REG_ADDR_W-1:0] rt_addr;
    logic [`DATA_WIDTH-1:0] rs_data;
    logic [`DATA_WIDTH-1:0] rt_data;

    // Stage records
    idex_t idex;
    wb_t   wb;

    instr_decoder u_decoder (
        .clk         ( clk ),
        .reset       ( reset ),
        .instr_valid ( instr_valid ),
        .instr       ( instr ),
        .rs_addr     ( rs_addr ),
        .rt_addr     ( rt_addr ),
        .rs_data     ( rs_data ),
        .rt_data     ( rt_data ),
        .idex        ( idex )
    );

    gpr u_gpr (
        .clk     ( clk ),
        .reset   ( reset ),
        .rs_addr ( rs_addr ),
        .rt_addr ( rt_addr ),
        .rs_data ( rs_data ),
        .rt_data ( rt_data ),
        .wb      ( wb )
    );

    exec_stage u_exec (
        .clk   ( clk ),
        .reset ( reset ),
        .idex  ( idex ),
        .wb    ( wb )
    );

    // Write-back strobe out
    assign wb_valid = wb.valid;
    assign wb_addr  = wb.rd_addr;
    assign wb_data  = wb.data;

endmodule

/* pipeline_checker.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module pipeline_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   instr_valid,
    input logic                   wb_valid,
    input logic [`REG_ADDR_W-1:0] wb_addr
);

    //////////////////////////////
    // Port rules
    //////////////////////////////

    // Reset clears the strobe by the next edge
    reset_clears_wb: assert property (@(posedge clk) reset |=> !wb_valid)
        else $error("wb_valid high during or right after reset");

    // r0 is never a write target
    no_r0_write: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_addr != '0)
        else $error("write-back to register 0");

    // Two-cycle latency from the instruction strobe
    wb_after_instr: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> $past(instr_valid, 2))
        else $error("wb_valid without instr_valid two cycles earlier");

    wb_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(wb_valid))
        else $error("wb_valid is unknown");

endmodule

bind pipeline pipeline_checker u_checker (
    .clk         ( clk ),
    .reset       ( reset ),
    .instr_valid ( instr_valid ),
    .wb_valid    ( wb_valid ),
    .wb_addr     ( wb_addr )
);

/* tb_pipeline.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_pipeline;

    //////////////////////////////
    // Run length
    //////////////////////////////

    localparam int SLOTS          = 2000;
    localparam int TIMEOUT_CYCLES = 2 * SLOTS + 20;

    // Expected write-back, with the cycle it must show up in
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
        logic [31:0]            cycle;
    } wb_exp_t;

    logic                      clk;
    logic                      reset;
    logic                      instr_valid;
    logic [`INSTR_WIDTH-1:0]   instr;
    logic                      wb_valid;
    logic [`REG_ADDR_W-1:0]    wb_addr;
    logic [`DATA_WIDTH-1:0]    wb_data;

    logic [31:0]               cycle = '0;
    logic [31:0]               last_issue = '0;
    logic [31:0]               lcg_state;
    logic [`DATA_WIDTH-1:0]    model_regs [`REG_COUNT];
    wb_exp_t                   exp_q [$];

    pipeline dut (
        .clk         ( clk ),
        .reset       ( reset ),
        .instr_valid ( instr_valid ),
        .instr       ( instr ),
        .wb_valid    ( wb_valid ),
        .wb_addr     ( wb_addr ),
        .wb_data     ( wb_data )
    );

    // 8 ns clock
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // Failure handling
    //////////////////////////////

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s mismatch, got 0x%08h, expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////
    // Random stimulus
    //////////////////////////////

    // LCG step, upper half is the better-mixed part
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // Half SPECIAL, the rest over the I-type opcodes
    function automatic logic [5:0] pick_opcode(input logic [15:0] r);
        if (r[15]) begin
            return 6'h00;
        end
        case (r[2:0])
            3'd0:    return 6'h09;
            3'd1:    return 6'h0a;
            3'd2:    return 6'h0b;
            3'd3:    return 6'h0c;
            3'd4:    return 6'h0d;
            3'd5:    return 6'h0e;
            default: return 6'h0f;
        endcase
    endfunction

    // Fourteen legal functions, two codes left raw and mostly illegal
    function automatic logic [5:0] pick_funct(input logic [15:0] r);
        case (r[3:0])
            4'd0:    return 6'h00;
            4'd1:    return 6'h02;
            4'd2:    return 6'h03;
            4'd3:    return 6'h04;
            4'd4:    return 6'h06;
            4'd5:    return 6'h07;
            4'd6:    return 6'h21;
            4'd7:    return 6'h23;
            4'd8:    return 6'h24;
            4'd9:    return 6'h25;
            4'd10:   return 6'h26;
            4'd11:   return 6'h27;
            4'd12:   return 6'h2a;
            4'd13:   return 6'h2b;
            default: return r[9:4];
        endcase
    endfunction

    function automatic logic [31:0] random_instr();
        logic [15:0] r_op;
        logic [15:0] r_fn;
        logic [15:0] r_reg;
        logic [15:0] imm;
        logic [5:0]  op;
        r_op  = lcg_next();
        r_fn  = lcg_next();
        r_reg = lcg_next();
        imm   = lcg_next();
        // One in eight opcodes drawn raw
        if (r_op[14:12] == 3'd0) begin
            op = r_op[11:6];
        end else begin
            op = pick_opcode(r_op);
        end
        // Registers 0..7 only, so dependencies are frequent
        if (op == 6'h00) begin
            return {op, 2'b00, r_reg[2:0], 2'b00, r_reg[5:3], 2'b00, r_reg[8:6],
                    r_reg[13:9], pick_funct(r_fn)};
        end
        return {op, 2'b00, r_reg[2:0], 2'b00, r_reg[5:3], imm};
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    task automatic model_execute(input logic [31:0] ins, output logic wr,
                                 output logic [4:0] dest, output logic [31:0] res);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        op   = ins[31:26];
        fn   = ins[5:0];
        sh   = ins[10:6];
        a    = model_regs[ins[25:21]];
        b    = model_regs[ins[20:16]];
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        wr   = 1'b1;
        dest = ins[20:16];
        res  = '0;
        if (op == 6'h00) begin
            dest = ins[15:11];
            case (fn)
                6'h00:   res = b << sh;
                6'h02:   res = b >> sh;
                6'h03:   res = $signed(b) >>> sh;
                // Variable shifts, low five bits of rs only
                6'h04:   res = b << a[4:0];
                6'h06:   res = b >> a[4:0];
                6'h07:   res = $signed(b) >>> a[4:0];
                6'h21:   res = a + b;
                6'h23:   res = a - b;
                6'h24:   res = a & b;
                6'h25:   res = a | b;
                6'h26:   res = a ^ b;
                6'h27:   res = ~(a | b);
                6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6'h2b:   res = (a < b) ? 32'd1 : 32'd0;
                default: wr = 1'b0;
            endcase
        end else begin
            case (op)
                6'h09:   res = a + simm;
                6'h0a:   res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                // sltiu still sign-extends, then compares unsigned
                6'h0b:   res = (a < simm) ? 32'd1 : 32'd0;
                6'h0c:   res = a & zimm;
                6'h0d:   res = a | zimm;
                6'h0e:   res = a ^ zimm;
                6'h0f:   res = {ins[15:0], 16'h0000};
                default: wr = 1'b0;
            endcase
        end
        // r0 stays zero
        if (dest == '0) begin
            wr = 1'b0;
        end
        if (wr) begin
            model_regs[dest] = res;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        logic [15:0] r;
        logic [31:0] ins;
        logic        strobe;
        logic        wr;
        logic [4:0]  dest;
        logic [31:0] res;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lcg_state   = 32'd26;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (int s = 0; s < SLOTS; s++) begin
            @(posedge clk);
            #1;
            r   = lcg_next();
            ins = random_instr();
            // Full rate first half, then gaps of random length
            strobe      = (s < SLOTS / 2) ? 1'b1 : (r[1:0] != 2'b00);
            instr_valid = strobe;
            instr       = ins;
            if (strobe) begin
                model_execute(ins, wr, dest, res);
                if (wr) begin
                    exp_q.push_back('{addr: dest, data: res, cycle: cycle + 2});
                end
            end
            last_issue = cycle;
        end
        @(posedge clk);
        #1 instr_valid = 1'b0;
        // Latency is fixed, so the last write is out by then
        wait (cycle >= last_issue + 4);
        if (exp_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("ERR %0t: %0d expected write-backs never arrived", $time, exp_q.size());
            abort_run();
        end
    end

    //////////////////////////////
    // Write-back monitor
    //////////////////////////////

    // Sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        wb_exp_t exp;
        if (!reset && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("Write-back to register %0d at %0t with no write pending",
                         wb_addr, $time);
                abort_run();
            end else begin
                exp = exp_q.pop_front();
                check_value("write-back address", wb_addr, exp.addr);
                check_value("write-back data", wb_data, exp.data);
                check_value("write-back cycle", cycle, exp.cycle);
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

endmodule

/* sources.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
instr_decoder.sv
gpr.sv
exec_stage.sv
pipeline.sv
pipeline_checker.sv
tb_pipeline.sv

/* Bender.yml */
package:
  name: pipeline_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - instr_decoder.sv
      - gpr.sv
      - exec_stage.sv
      - pipeline.sv
  - target: test
    include_dirs:
      - .
    files:
      - pipeline_checker.sv
      - tb_pipeline.sv
